/* src/pulse_cfg_pkg.sv */
package pulse_cfg_pkg;

	// Pulse count field, number of pulses in one train
	localparam int CNT_BITS = 8;

	// Pulse width field, in ticks for each half period
	localparam int WID_BITS = 8;

	// Tick divisor, also the width of the host write data
	localparam int DIV_BITS = 12;

	// Train shape as captured by the generator at the start of a train
	typedef struct packed {
		logic [CNT_BITS-1:0] count;
		logic [WID_BITS-1:0] width;
	} pulse_shape_t;

endpackage : pulse_cfg_pkg

/* src/pulse_ctrl_pkg.sv */
package pulse_ctrl_pkg;

	// Sequencer states
	typedef enum logic [1:0] {
		SEQ_IDLE    = 2'd0,
		SEQ_PREPARE = 2'd1,
		SEQ_RUN     = 2'd2
	} seq_state_e;

	// Host register map, decoded from the write address
	typedef enum logic [1:0] {
		REG_DIVISOR = 2'd0,
		REG_COUNT   = 2'd1,
		REG_WIDTH   = 2'd2,
		REG_START   = 2'd3
	} reg_addr_e;

endpackage : pulse_ctrl_pkg

/* src/tick_prescaler.sv */
`timescale 1ns/1ns

module tick_prescaler (
	input  logic                             clk,
	input  logic                             reset,
	input  logic [pulse_cfg_pkg::DIV_BITS-1:0] divisor,
	output logic                             tick
);

	import pulse_cfg_pkg::*;

	logic [DIV_BITS-1:0] count_q;
	logic                wrap;

	// Counter at zero means a tick is due on the next cycle
	assign wrap = (count_q == '0);

	always_ff @(posedge clk) begin
		if (reset) begin
			count_q <= '0;
			tick <= 1'b0;
		end
		else begin
			tick <= wrap;
			// Divisor is only sampled on reload
			if (wrap) begin
				count_q <= divisor;
			end
			else begin
				count_q <= count_q - 1'b1;
			end
		end
	end

	// A tick reloads the counter from the divisor seen one cycle before it,
	// so a nonzero divisor there leaves at least one quiet cycle
	a_tick_spacing : assert property (
		@(posedge clk) disable iff (reset)
		(tick && $past(divisor) != '0) |=> !tick
	) else $error("tick_prescaler: back to back ticks with nonzero divisor");

endmodule : tick_prescaler

/* src/pulse_config_regs.sv */
`timescale 1ns/1ns

module pulse_config_regs #(
	parameter logic [pulse_cfg_pkg::DIV_BITS-1:0] RESET_DIVISOR = 'd3
) (
	input  logic                               clk,
	input  logic                               reset,
	input  logic                               wr_en,
	input  pulse_ctrl_pkg::reg_addr_e          wr_addr,
	input  logic [pulse_cfg_pkg::DIV_BITS-1:0] wr_data,
	input  logic                               done,
	output logic [pulse_cfg_pkg::DIV_BITS-1:0] divisor,
	output pulse_cfg_pkg::pulse_shape_t        shape,
	output logic                               start_req
);

	import pulse_cfg_pkg::*;
	import pulse_ctrl_pkg::*;

	logic start_wr;

	assign start_wr = wr_en && (wr_addr == REG_START);

	// Setting registers, written one cycle after the strobe
	always_ff @(posedge clk) begin
		if (reset) begin
			divisor <= RESET_DIVISOR;
			shape <= '0;
		end
		else if (wr_en) begin
			case (wr_addr)
				REG_DIVISOR: begin
					divisor <= wr_data;
				end
				REG_COUNT: begin
					shape.count <= wr_data[CNT_BITS-1:0];
				end
				REG_WIDTH: begin
					shape.width <= wr_data[WID_BITS-1:0];
				end
				default: begin
					// Start command is handled by the request logic
				end
			endcase
		end
	end

	// Start request is held until the generator leaves idle
	always_ff @(posedge clk) begin
		if (reset) begin
			start_req <= 1'b0;
		end
		else if (!done) begin
			start_req <= 1'b0;
		end
		else if (start_wr) begin
			start_req <= 1'b1;
		end
	end

	// A start written during a train must be dropped
	a_no_start_while_busy : assert property (
		@(posedge clk) disable iff (reset)
		$rose(start_req) |-> $past(done)
	) else $error("pulse_config_regs: start request raised while busy");

endmodule : pulse_config_regs

/* src/pulse_seq_fsm.sv */
`timescale 1ns/1ns

module pulse_seq_fsm (
	input  logic                       clk,
	input  logic                       reset,
	input  logic                       tick,
	input  logic                       start_req,
	input  logic                       last_reached,
	input  logic                       zero_shape,
	output pulse_ctrl_pkg::seq_state_e state
);

	import pulse_ctrl_pkg::*;

	seq_state_e state_next;

	always_comb begin
		state_next = state;
		unique case (state)
			SEQ_IDLE: begin
				if (start_req) begin
					state_next = SEQ_PREPARE;
				end
			end
			SEQ_PREPARE: begin
				// Empty train goes straight back
				state_next = zero_shape ? SEQ_IDLE : SEQ_RUN;
			end
			SEQ_RUN: begin
				if (last_reached) begin
					state_next = SEQ_IDLE;
				end
			end
			default: begin
				state_next = SEQ_IDLE;
			end
		endcase
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			state <= SEQ_IDLE;
		end
		else if (tick) begin
			state <= state_next;
		end
	end

	// Train can only begin on a prescaler tick
	a_leave_idle_on_tick : assert property (
		@(posedge clk) disable iff (reset)
		(state == SEQ_IDLE && !tick) |=> (state == SEQ_IDLE)
	) else $error("pulse_seq_fsm: left idle without a tick");

endmodule : pulse_seq_fsm

/* src/pulse_train_gen.sv */
`timescale 1ns/1ns

module pulse_train_gen (
	input  logic                        clk,
	input  logic                        reset,
	input  logic                        tick,
	input  pulse_cfg_pkg::pulse_shape_t shape,
	input  pulse_ctrl_pkg::seq_state_e  state,
	output logic                        last_reached,
	output logic                        zero_shape,
	output logic                        pulse_out,
	output logic                        done
);

	import pulse_cfg_pkg::*;
	import pulse_ctrl_pkg::*;

	pulse_shape_t shape_q;

	// Width counter spans both halves of a pulse period
	logic [WID_BITS:0]   width_cnt;
	logic [CNT_BITS-1:0] count_cnt;
	logic [WID_BITS:0]   width_end;
	logic [CNT_BITS-1:0] count_end;
	logic                width_last;
	logic                count_last;
	logic                run_next;
	logic [WID_BITS:0]   width_nxt;
	logic [CNT_BITS-1:0] count_nxt;

	// Settings follow the registers while idle and freeze once a train starts
	always_ff @(posedge clk) begin
		if (tick && state == SEQ_IDLE) begin
			shape_q <= shape;
		end
	end

	assign zero_shape = (shape_q.count == '0) || (shape_q.width == '0);

	assign width_end = {shape_q.width, 1'b0} - 1'b1;
	assign count_end = shape_q.count - 1'b1;
	assign width_last = (width_cnt == width_end);
	assign count_last = (count_cnt == count_end);

	assign last_reached = (state == SEQ_RUN) && width_last && count_last;

	// Whether the next tick leaves the sequencer in SEQ_RUN
	assign run_next = ((state == SEQ_RUN) && !last_reached) ||
		((state == SEQ_PREPARE) && !zero_shape);

	always_comb begin
		width_nxt = '0;
		count_nxt = '0;
		if (run_next && state == SEQ_RUN) begin
			if (width_last) begin
				count_nxt = count_cnt + 1'b1;
			end
			else begin
				width_nxt = width_cnt + 1'b1;
				count_nxt = count_cnt;
			end
		end
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			width_cnt <= '0;
			count_cnt <= '0;
			pulse_out <= 1'b0;
		end
		else if (tick) begin
			width_cnt <= width_nxt;
			count_cnt <= count_nxt;
			// High for the first half of each period, low after the last one
			pulse_out <= run_next && (width_nxt < {1'b0, shape_q.width});
		end
	end

	// State is a register, so done moves on the same edge as the sequencer
	assign done = (state == SEQ_IDLE);

	// Output is only ever high inside a train
	a_pulse_only_when_busy : assert property (
		@(posedge clk) disable iff (reset)
		pulse_out |-> !done
	) else $error("pulse_train_gen: pulse_out high while done");

endmodule : pulse_train_gen

/* src/pulse_unit_top.sv */
`timescale 1ns/1ns

module pulse_unit_top #(
	parameter logic [pulse_cfg_pkg::DIV_BITS-1:0] RESET_DIVISOR = 'd3
) (
	input  logic                               clk,
	input  logic                               reset,
	input  logic                               wr_en,
	input  pulse_ctrl_pkg::reg_addr_e          wr_addr,
	input  logic [pulse_cfg_pkg::DIV_BITS-1:0] wr_data,
	output logic                               pulse_out,
	output logic                               done
);

	import pulse_cfg_pkg::*;
	import pulse_ctrl_pkg::*;

	logic [DIV_BITS-1:0] divisor;
	pulse_shape_t        shape;
	logic                start_req;
	logic                tick;
	seq_state_e          state;
	logic                last_reached;
	logic                zero_shape;

	pulse_config_regs #(
		.RESET_DIVISOR(RESET_DIVISOR)
	) u_regs (
		.clk(clk),
		.reset(reset),
		.wr_en(wr_en),
		.wr_addr(wr_addr),
		.wr_data(wr_data),
		.done(done),
		.divisor(divisor),
		.shape(shape),
		.start_req(start_req)
	);

	tick_prescaler u_prescaler (
		.clk(clk),
		.reset(reset),
		.divisor(divisor),
		.tick(tick)
	);

	pulse_seq_fsm u_seq (
		.clk(clk),
		.reset(reset),
		.tick(tick),
		.start_req(start_req),
		.last_reached(last_reached),
		.zero_shape(zero_shape),
		.state(state)
	);

	pulse_train_gen u_gen (
		.clk(clk),
		.reset(reset),
		.tick(tick),
		.shape(shape),
		.state(state),
		.last_reached(last_reached),
		.zero_shape(zero_shape),
		.pulse_out(pulse_out),
		.done(done)
	);

endmodule : pulse_unit_top

/* dv/pulse_unit_checker.sv */
`timescale 1ns/1ns

module pulse_unit_checker #(
	parameter logic [pulse_cfg_pkg::DIV_BITS-1:0] RESET_DIVISOR = 'd3
) (
	input  logic                               clk,
	input  logic                               reset,
	input  logic                               wr_en,
	input  pulse_ctrl_pkg::reg_addr_e          wr_addr,
	input  logic [pulse_cfg_pkg::DIV_BITS-1:0] wr_data,
	input  logic                               pulse_out,
	input  logic                               done,
	input  logic [8*16-1:0]                    test_name
);

	import pulse_cfg_pkg::*;
	import pulse_ctrl_pkg::*;

	// Raised by any failing check, watched by the testbench top
	event check_failed;

	logic [DIV_BITS-1:0] shadow_div;
	logic [DIV_BITS-1:0] snap_div;
	pulse_shape_t        shadow_shape;
	pulse_shape_t        snap_shape;
	logic                started;
	logic                pending;
	logic                pulse_q;
	logic [31:0]         high_run;
	logic [31:0]         low_run;
	logic [31:0]         busy_run;
	logic [31:0]         rise_cnt;
	logic [31:0]         exp_phase;
	logic [31:0]         exp_pulses;
	logic [31:0]         exp_busy;

	// Host view of the register map
	always_ff @(posedge clk) begin
		if (reset) begin
			shadow_div <= RESET_DIVISOR;
			shadow_shape <= '0;
		end
		else if (wr_en) begin
			case (wr_addr)
				REG_DIVISOR: begin
					shadow_div <= wr_data;
				end
				REG_COUNT: begin
					shadow_shape.count <= wr_data[CNT_BITS-1:0];
				end
				REG_WIDTH: begin
					shadow_shape.width <= wr_data[WID_BITS-1:0];
				end
				default: begin
				end
			endcase
		end
	end

	// Settings of the current train, last taken on the edge where done falls
	always_ff @(posedge clk) begin
		if (reset) begin
			snap_div <= RESET_DIVISOR;
			snap_shape <= '0;
		end
		else if (done) begin
			snap_div <= shadow_div;
			snap_shape <= shadow_shape;
		end
	end

	// A start only counts when written while idle
	always_ff @(posedge clk) begin
		if (reset) begin
			started <= 1'b0;
			pending <= 1'b0;
		end
		else begin
			if (wr_en && wr_addr == REG_START) begin
				started <= 1'b1;
			end
			if (!done) begin
				pending <= 1'b0;
			end
			else if (wr_en && wr_addr == REG_START) begin
				pending <= 1'b1;
			end
		end
	end

	// Run lengths in clock cycles and rising edges per train
	always_ff @(posedge clk) begin
		if (reset) begin
			pulse_q <= 1'b0;
			high_run <= '0;
			low_run <= '0;
			busy_run <= '0;
			rise_cnt <= '0;
		end
		else begin
			pulse_q <= pulse_out;
			high_run <= pulse_out ? high_run + 32'd1 : 32'd0;
			low_run <= pulse_out ? 32'd0 : low_run + 32'd1;
			busy_run <= done ? 32'd0 : busy_run + 32'd1;
			if (done) begin
				rise_cnt <= '0;
			end
			else if (pulse_out && !pulse_q) begin
				rise_cnt <= rise_cnt + 32'd1;
			end
		end
	end

	always_comb begin
		exp_phase = 32'(snap_shape.width) * (32'(snap_div) + 32'd1);
		if (snap_shape.count == '0 || snap_shape.width == '0) begin
			exp_pulses = 32'd0;
		end
		else begin
			exp_pulses = 32'(snap_shape.count);
		end
		exp_busy = (32'd1 + 32'd2 * 32'(snap_shape.width) * 32'(snap_shape.count)) *
			(32'(snap_div) + 32'd1);
	end

	a_idle_after_reset : assert property (
		@(posedge clk) disable iff (reset)
		!started |-> (done && !pulse_out)
	) else begin
		$display("error %0s: idle done/pulse expected 1/0 actual %0b/%0b",
			test_name, done, pulse_out);
		-> check_failed;
	end

	a_high_phase : assert property (
		@(posedge clk) disable iff (reset)
		$fell(pulse_out) |-> (high_run == exp_phase)
	) else begin
		$display("error %0s: high phase expected %0d actual %0d",
			test_name, exp_phase, high_run);
		-> check_failed;
	end

	// Low phase before the first pulse is the prepare tick, so skip it
	a_low_phase : assert property (
		@(posedge clk) disable iff (reset)
		($rose(pulse_out) && rise_cnt != 0) |-> (low_run == exp_phase)
	) else begin
		$display("error %0s: low phase expected %0d actual %0d",
			test_name, exp_phase, low_run);
		-> check_failed;
	end

	a_pulse_count : assert property (
		@(posedge clk) disable iff (reset)
		$rose(done) |-> (rise_cnt == exp_pulses)
	) else begin
		$display("error %0s: pulse count expected %0d actual %0d",
			test_name, exp_pulses, rise_cnt);
		-> check_failed;
	end

	a_busy_length : assert property (
		@(posedge clk) disable iff (reset)
		$rose(done) |-> (busy_run == exp_busy)
	) else begin
		$display("error %0s: busy cycles expected %0d actual %0d",
			test_name, exp_busy, busy_run);
		-> check_failed;
	end

	a_start_needed : assert property (
		@(posedge clk) disable iff (reset)
		$fell(done) |-> pending
	) else begin
		$display("%0s: a train began without a start written while idle", test_name);
		-> check_failed;
	end

endmodule : pulse_unit_checker

/* dv/pulse_unit_tb.sv */
`timescale 1ns/1ns

module pulse_unit_tb;

	import pulse_cfg_pkg::*;
	import pulse_ctrl_pkg::*;

	typedef logic [8*16-1:0] test_label_t;

	localparam int CLK_PERIOD = 100;
	localparam logic [DIV_BITS-1:0] RESET_DIV = 12'd3;

	// Random settings take three bits each
	localparam int DIV_MAX = 7;
	localparam int WID_MAX = 8;
	localparam int CNT_MAX = 8;
	localparam int N_RANDOM = 8;

	// Random trains, two zero trains, one frozen train and two back to back
	localparam int N_TRAINS = N_RANDOM + 5;
	localparam int TRAIN_MAX = (1 + 2 * WID_MAX * CNT_MAX) * (DIV_MAX + 1);
	localparam int WAIT_LIMIT = TRAIN_MAX + 64;
	localparam int WATCHDOG_CYCLES = N_TRAINS * WAIT_LIMIT + 200;

	logic                clk;
	logic                reset;
	logic                wr_en;
	reg_addr_e           wr_addr;
	logic [DIV_BITS-1:0] wr_data;
	logic                pulse_out;
	logic                done;
	test_label_t         test_name;
	logic [31:0]         lfsr_state;

	pulse_unit_top #(
		.RESET_DIVISOR(RESET_DIV)
	) dut (
		.clk(clk),
		.reset(reset),
		.wr_en(wr_en),
		.wr_addr(wr_addr),
		.wr_data(wr_data),
		.pulse_out(pulse_out),
		.done(done)
	);

	pulse_unit_checker #(
		.RESET_DIVISOR(RESET_DIV)
	) chk (
		.clk(clk),
		.reset(reset),
		.wr_en(wr_en),
		.wr_addr(wr_addr),
		.wr_data(wr_data),
		.pulse_out(pulse_out),
		.done(done),
		.test_name(test_name)
	);

	task automatic stop_with_failure(input string reason);
		$display("%s", reason);
		$display(">>> FAIL");
		$fatal(1, "simulation stopped");
	endtask

	// Galois LFSR, taps for a maximal length 32-bit sequence
	function automatic logic [31:0] lfsr_step(input logic [31:0] state);
		lfsr_step = state[0] ? ((state >> 1) ^ 32'h8020_0003) : (state >> 1);
	endfunction

	task automatic random_bits(input int nbits, output logic [31:0] value);
		value = '0;
		for (int i = 0; i < nbits; i++) begin
			value = {value[30:0], lfsr_state[0]};
			lfsr_state = lfsr_step(lfsr_state);
		end
	endtask

	task automatic write_reg(input reg_addr_e addr, input logic [DIV_BITS-1:0] data);
		wr_en = 1'b1;
		wr_addr = addr;
		wr_data = data;
		@(negedge clk);
		wr_en = 1'b0;
	endtask

	task automatic wait_done_fall();
		int cycles;
		cycles = 0;
		while (done && cycles < WAIT_LIMIT) begin
			@(negedge clk);
			cycles++;
		end
		if (done) begin
			stop_with_failure("done did not fall after a start write");
		end
	endtask

	task automatic wait_done_rise();
		int cycles;
		cycles = 0;
		while (!done && cycles < WAIT_LIMIT) begin
			@(negedge clk);
			cycles++;
		end
		if (!done) begin
			stop_with_failure("done did not rise at the end of a train");
		end
	endtask

	// Settings first, start last, then one full train
	task automatic run_train(
		input logic [DIV_BITS-1:0] div,
		input logic [DIV_BITS-1:0] wid,
		input logic [DIV_BITS-1:0] cnt
	);
		write_reg(REG_DIVISOR, div);
		write_reg(REG_WIDTH, wid);
		write_reg(REG_COUNT, cnt);
		write_reg(REG_START, 12'd0);
		wait_done_fall();
		wait_done_rise();
		repeat (2) @(negedge clk);
	endtask

	initial begin
		clk = 1'b0;
		forever #(CLK_PERIOD / 2) clk = ~clk;
	end

	initial begin
		#(WATCHDOG_CYCLES * CLK_PERIOD);
		stop_with_failure("watchdog expired before all tests finished");
	end

	initial begin
		@(chk.check_failed);
		stop_with_failure("a check on the output train failed");
	end

	initial begin
		logic [31:0] rnd_div;
		logic [31:0] rnd_wid;
		logic [31:0] rnd_cnt;
		lfsr_state = 32'hb9d7;
		reset = 1'b1;
		wr_en = 1'b0;
		wr_addr = REG_DIVISOR;
		wr_data = '0;
		test_name = test_label_t'("reset_idle");
		repeat (2) @(negedge clk);
		reset = 1'b0;
		repeat (20) @(negedge clk);

		test_name = test_label_t'("random_shape");
		for (int i = 0; i < N_RANDOM; i++) begin
			random_bits(3, rnd_div);
			random_bits(3, rnd_wid);
			random_bits(3, rnd_cnt);
			// First train ticks on every clock
			if (i == 0) begin
				rnd_div = '0;
			end
			run_train(rnd_div[DIV_BITS-1:0], rnd_wid[DIV_BITS-1:0] + 12'd1,
				rnd_cnt[DIV_BITS-1:0] + 12'd1);
		end

		test_name = test_label_t'("zero_count");
		run_train(12'd1, 12'd3, 12'd0);
		test_name = test_label_t'("zero_width");
		run_train(12'd0, 12'd0, 12'd4);

		// New shape and a second start arrive while the train runs
		test_name = test_label_t'("frozen_settings");
		write_reg(REG_DIVISOR, 12'd2);
		write_reg(REG_WIDTH, 12'd3);
		write_reg(REG_COUNT, 12'd3);
		write_reg(REG_START, 12'd0);
		wait_done_fall();
		write_reg(REG_COUNT, 12'd7);
		write_reg(REG_WIDTH, 12'd1);
		write_reg(REG_START, 12'd0);
		wait_done_rise();
		repeat (12) @(negedge clk);

		test_name = test_label_t'("back_to_back");
		write_reg(REG_DIVISOR, 12'd1);
		write_reg(REG_WIDTH, 12'd2);
		write_reg(REG_COUNT, 12'd2);
		write_reg(REG_START, 12'd0);
		wait_done_fall();
		write_reg(REG_WIDTH, 12'd5);
		write_reg(REG_COUNT, 12'd3);
		wait_done_rise();
		write_reg(REG_START, 12'd0);
		wait_done_fall();
		wait_done_rise();
		repeat (4) @(negedge clk);

		$display(">>> PASS");
		$finish;
	end

endmodule : pulse_unit_tb

/* sources.f */
src/pulse_cfg_pkg.sv
src/pulse_ctrl_pkg.sv
src/tick_prescaler.sv
src/pulse_config_regs.sv
src/pulse_seq_fsm.sv
src/pulse_train_gen.sv
src/pulse_unit_top.sv
dv/pulse_unit_checker.sv
dv/pulse_unit_tb.sv

/* run.sh */
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -j 0 \
	--top-module pulse_unit_tb -f sources.f -o pulse_unit_sim

output=$(./obj_dir/pulse_unit_sim 2>&1) || true
printf '%s\n' "$output"

if printf '%s\n' "$output" | grep -qx '>>> PASS'; then
	exit 0
fi
exit 1
